/* io_map_pkg.sv */
/* Address map of the I/O port windows. Each window holds PORT_COUNT consecutive
   addresses, and PORT_INDEX_WIDTH must equal clog2 of PORT_COUNT */

package io_map_pkg;

    // --------------------
    // Address space

    // Width of both the read address and the write address of an access
    localparam int unsigned ADDR_WIDTH = 10;

    // --------------------
    // Port windows

    // Ports of each kind, so the read and write windows have the same size
    localparam int unsigned PORT_COUNT = 4;

    // Bits needed to select one port inside a window
    localparam int unsigned PORT_INDEX_WIDTH = 2;

    // A window must fit in the address space, otherwise the offset
    // arithmetic in the window decode would wrap onto ordinary addresses
    localparam int unsigned ADDR_SPACE = 1 << ADDR_WIDTH;

    // Largest base address that keeps a whole window inside the space
    localparam int unsigned MAX_BASE_ADDR = ADDR_SPACE - PORT_COUNT;

endpackage

/* io_access_pkg.sv */
/* Request and result formats of the I/O access pipeline.
   Field widths follow the address map, so both packages must compile together */

package io_access_pkg;

    // Tag carried unchanged from request to result
    localparam int unsigned TAG_WIDTH = 8;

    // --------------------
    // Opcodes

    // Each bit of the encoding names one side of the access
    typedef enum logic [1:0] {
        OP_NONE       = 2'b00,
        OP_READ       = 2'b01,
        OP_WRITE      = 2'b10,
        OP_READ_WRITE = 2'b11
    } op_e;

    // --------------------
    // Request, 30 bits

    typedef struct packed {
        op_e                                  op;
        logic [io_map_pkg::ADDR_WIDTH-1:0]    rd_addr;
        logic [io_map_pkg::ADDR_WIDTH-1:0]    wr_addr;
        logic [TAG_WIDTH-1:0]                 tag;
    } access_req_t;

    // --------------------
    // Result, 17 bits

    // An annulled result always has rden and wren at zero
    typedef struct packed {
        logic [io_map_pkg::PORT_COUNT-1:0]    rden;
        logic [io_map_pkg::PORT_COUNT-1:0]    wren;
        logic                                 annulled;
        logic [TAG_WIDTH-1:0]                 tag;
    } access_result_t;

endpackage

/* io_port_check.sv */
/* Stage 1 window decode. BASE_ADDR plus PORT_COUNT must not pass the top of the
   address space. A port counts as ready when its flag is low */

`timescale 1ns/10ps

module io_port_check #(
    parameter logic [io_map_pkg::ADDR_WIDTH-1:0] BASE_ADDR = '0
) (
    input  logic                                      clock,
    input  logic                                      rst,
    input  logic                                      advance,
    input  logic                                      use_port,
    input  logic [io_map_pkg::ADDR_WIDTH-1:0]         addr,
    input  logic [io_map_pkg::PORT_COUNT-1:0]         port_flags,
    output logic                                      is_io,
    output logic [io_map_pkg::PORT_INDEX_WIDTH-1:0]   port_index,
    output logic                                      port_ready
);

    logic [io_map_pkg::ADDR_WIDTH-1:0]         offset;
    logic                                      in_window;
    logic [io_map_pkg::PORT_INDEX_WIDTH-1:0]   index_next;
    logic                                      hit;

    // --------------------
    // Window decode

    // Addresses below the base wrap to large offsets and fall outside
    assign offset     = addr - BASE_ADDR;
    assign in_window  = offset < io_map_pkg::ADDR_WIDTH'(io_map_pkg::PORT_COUNT);
    assign index_next = offset[io_map_pkg::PORT_INDEX_WIDTH-1:0];

    // Only a side that the opcode actually uses can hit the window
    assign hit = in_window & use_port;

    // --------------------
    // Stage 1 registers

    // The flag is sampled on the same edge that accepts the request.
    // A miss reports ready so that it never annuls the access
    always_ff @(posedge clock) begin
        if (rst) begin
            is_io      <= 1'b0;
            port_ready <= 1'b1;
        end else if (advance) begin
            is_io      <= hit;
            port_ready <= hit ? ~port_flags[index_next] : 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            port_index <= index_next;
        end
    end

endmodule

/* io_port_select.sv */
/* Stage 2 one-hot port enable decode.
   The enable is all zero whenever the stage 1 access missed the window */

`timescale 1ns/10ps

module io_port_select (
    input  logic                                      clock,
    input  logic                                      rst,
    input  logic                                      advance,
    input  logic                                      enable,
    input  logic [io_map_pkg::PORT_INDEX_WIDTH-1:0]   port_index,
    input  logic                                      ready_in,
    output logic [io_map_pkg::PORT_COUNT-1:0]         active,
    output logic                                      ready_out
);

    logic [io_map_pkg::PORT_COUNT-1:0] decoded;

    // --------------------
    // One-hot decode

    always_comb begin
        decoded = '0;
        if (enable) begin
            decoded[port_index] = 1'b1;
        end
    end

    // --------------------
    // Stage 2 registers

    // Ready moves with the enable so both reach issue control together
    always_ff @(posedge clock) begin
        if (rst) begin
            active    <= '0;
            ready_out <= 1'b1;
        end else if (advance) begin
            active    <= decoded;
            ready_out <= ready_in;
        end
    end

endmodule

/* io_access_predication.sv */
/* Predication chain for one port kind, read or write. Enable and ready come out
   two advances after the address, for use by the stage 3 annul decision */

`timescale 1ns/10ps

module io_access_predication #(
    parameter logic [io_map_pkg::ADDR_WIDTH-1:0] BASE_ADDR = '0
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                advance,
    input  logic                                use_port,
    input  logic [io_map_pkg::ADDR_WIDTH-1:0]   addr,
    input  logic [io_map_pkg::PORT_COUNT-1:0]   port_flags,
    output logic [io_map_pkg::PORT_COUNT-1:0]   port_enable,
    output logic                                port_ready
);

    // Stage 1 outputs of the window check
    logic                                      s1_is_io;
    logic [io_map_pkg::PORT_INDEX_WIDTH-1:0]   s1_port_index;
    logic                                      s1_port_ready;

    // --------------------
    // Stage 1

    // Decides whether the address is one of our ports and samples its flag
    io_port_check #(
        .BASE_ADDR  (BASE_ADDR)
    ) u_check (
        .clock      (clock),
        .rst        (rst),
        .advance    (advance),
        .use_port   (use_port),
        .addr       (addr),
        .port_flags (port_flags),
        .is_io      (s1_is_io),
        .port_index (s1_port_index),
        .port_ready (s1_port_ready)
    );

    // --------------------
    // Stage 2

    // The enable is raw here.
    // Issue control zeroes it when either side of the access was not ready,
    // since only then is the readiness of the whole access known
    io_port_select u_select (
        .clock      (clock),
        .rst        (rst),
        .advance    (advance),
        .enable     (s1_is_io),
        .port_index (s1_port_index),
        .ready_in   (s1_port_ready),
        .active     (port_enable),
        .ready_out  (port_ready)
    );

endmodule

/* io_issue_control.sv */
/* Valid tracking, global stall and annul decision. All stages move on one advance,
   so a stalled result also holds the two stages behind it */

`timescale 1ns/10ps

module io_issue_control (
    input  logic                                 clock,
    input  logic                                 rst,
    input  io_access_pkg::access_req_t           req,
    input  logic                                 req_valid,
    output logic                                 req_ready,
    output logic                                 advance,
    output logic                                 rd_use,
    output logic                                 wr_use,
    input  logic [io_map_pkg::PORT_COUNT-1:0]    rd_enable,
    input  logic                                 rd_ready,
    input  logic [io_map_pkg::PORT_COUNT-1:0]    wr_enable,
    input  logic                                 wr_ready,
    output io_access_pkg::access_result_t        result,
    output logic                                 result_valid,
    input  logic                                 result_ready
);

    logic                                  s1_valid;
    logic                                  s2_valid;
    logic [io_access_pkg::TAG_WIDTH-1:0]   s1_tag;
    logic [io_access_pkg::TAG_WIDTH-1:0]   s2_tag;
    logic                                  annul;

    // --------------------
    // Stall and opcode decode

    // The pipeline moves when the result slot is free or being taken
    assign advance   = ~result_valid | result_ready;
    assign req_ready = advance;

    always_comb begin
        rd_use = 1'b0;
        wr_use = 1'b0;
        case (req.op)
            io_access_pkg::OP_READ:       rd_use = 1'b1;
            io_access_pkg::OP_WRITE:      wr_use = 1'b1;
            io_access_pkg::OP_READ_WRITE: begin
                rd_use = 1'b1;
                wr_use = 1'b1;
            end
            default: ;
        endcase
    end

    // --------------------
    // Stage tracking

    always_ff @(posedge clock) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else if (advance) begin
            s1_valid     <= req_valid;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid;
        end
    end

    // Unused sides report ready, so one blocked side annuls the whole access
    assign annul = ~(rd_ready & wr_ready);

    // Stage 3 result register, held while the result waits to be taken
    always_ff @(posedge clock) begin
        if (advance) begin
            s1_tag          <= req.tag;
            s2_tag          <= s1_tag;
            result.rden     <= annul ? '0 : rd_enable;
            result.wren     <= annul ? '0 : wr_enable;
            result.annulled <= annul;
            result.tag      <= s2_tag;
        end
    end

endmodule

/* io_predication_top.sv */
/* I/O access predication pipeline, three stages deep. Port flags are taken on the
   accepting edge, so later flag changes do not affect an access in flight */

`timescale 1ns/10ps

module io_predication_top #(
    parameter logic [io_map_pkg::ADDR_WIDTH-1:0] RD_BASE_ADDR = 10'h200,
    parameter logic [io_map_pkg::ADDR_WIDTH-1:0] WR_BASE_ADDR = 10'h300
) (
    input  logic                                 clock,
    input  logic                                 rst,
    input  io_access_pkg::access_req_t           req,
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic [io_map_pkg::PORT_COUNT-1:0]    rd_empty,
    input  logic [io_map_pkg::PORT_COUNT-1:0]    wr_full,
    output io_access_pkg::access_result_t        result,
    output logic                                 result_valid,
    input  logic                                 result_ready
);

    logic                                 advance;
    logic                                 rd_use;
    logic                                 wr_use;
    logic [io_map_pkg::PORT_COUNT-1:0]    rd_enable;
    logic                                 rd_ready;
    logic [io_map_pkg::PORT_COUNT-1:0]    wr_enable;
    logic                                 wr_ready;

    // --------------------
    // Read and write chains

    // A read port is ready when not empty
    io_access_predication #(
        .BASE_ADDR   (RD_BASE_ADDR)
    ) u_read (
        .clock       (clock),
        .rst         (rst),
        .advance     (advance),
        .use_port    (rd_use),
        .addr        (req.rd_addr),
        .port_flags  (rd_empty),
        .port_enable (rd_enable),
        .port_ready  (rd_ready)
    );

    // A write port is ready when not full
    io_access_predication #(
        .BASE_ADDR   (WR_BASE_ADDR)
    ) u_write (
        .clock       (clock),
        .rst         (rst),
        .advance     (advance),
        .use_port    (wr_use),
        .addr        (req.wr_addr),
        .port_flags  (wr_full),
        .port_enable (wr_enable),
        .port_ready  (wr_ready)
    );

    // --------------------
    // Issue control

    io_issue_control u_issue_control (
        .clock        (clock),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .advance      (advance),
        .rd_use       (rd_use),
        .wr_use       (wr_use),
        .rd_enable    (rd_enable),
        .rd_ready     (rd_ready),
        .wr_enable    (wr_enable),
        .wr_ready     (wr_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

endmodule

/* tb_io_predication.sv */
/* Self-checking testbench for the I/O predication pipeline. Expected results come from
   a queue model of the annul rule, using the port flags present at the accepting edge */

`timescale 1ns/10ps

module tb_io_predication;

    localparam logic [io_map_pkg::ADDR_WIDTH-1:0] RD_BASE = 10'h200;
    localparam logic [io_map_pkg::ADDR_WIDTH-1:0] WR_BASE = 10'h300;
    localparam int RANDOM_REQUESTS = 200;
    localparam int TOTAL_REQUESTS  = RANDOM_REQUESTS + 19;
    localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * 40 + 200;

    logic                                  clock;
    logic                                  rst;
    io_access_pkg::access_req_t            req;
    logic                                  req_valid;
    logic                                  req_ready;
    logic [io_map_pkg::PORT_COUNT-1:0]     rd_empty;
    logic [io_map_pkg::PORT_COUNT-1:0]     wr_full;
    io_access_pkg::access_result_t         result;
    logic                                  result_valid;
    logic                                  result_ready;

    int                                    seed = 32'h76f813d4;
    logic                                  random_ready = 1'b0;
    logic [io_access_pkg::TAG_WIDTH-1:0]   next_tag = '0;
    int                                    cycle_count = 0;
    int                                    check_errors = 0;
    int                                    sequence_errors = 0;

    // Model state holds one entry per accepted request in acceptance order
    io_access_pkg::access_result_t         expected_q[$];
    int                                    accept_cycle_q[$];
    bit                                    latency_q[$];
    logic                                  hold_pending = 1'b0;
    io_access_pkg::access_result_t         held_result;

    io_predication_top #(
        .RD_BASE_ADDR (RD_BASE),
        .WR_BASE_ADDR (WR_BASE)
    ) u_io_predication_top (
        .clock        (clock),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .rd_empty     (rd_empty),
        .wr_full      (wr_full),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // --------------------
    // Reference model

    // Models one side of an access. A used address inside the window enables its port,
    // and that port blocks the access when its flag is high
    function automatic void model_side(
        input  logic                                used,
        input  logic [io_map_pkg::ADDR_WIDTH-1:0]   addr,
        input  logic [io_map_pkg::ADDR_WIDTH-1:0]   base,
        input  logic [io_map_pkg::PORT_COUNT-1:0]   flags,
        output logic [io_map_pkg::PORT_COUNT-1:0]   enable,
        output logic                                blocked
    );
        int                                       offset;
        logic [io_map_pkg::PORT_INDEX_WIDTH-1:0]  index;
        offset  = int'(addr) - int'(base);
        index   = offset[io_map_pkg::PORT_INDEX_WIDTH-1:0];
        enable  = '0;
        blocked = 1'b0;
        if (used && offset >= 0 && offset < int'(io_map_pkg::PORT_COUNT)) begin
            enable[index] = 1'b1;
            blocked       = flags[index];
        end
    endfunction

    function automatic io_access_pkg::access_result_t expected_result(
        input io_access_pkg::access_req_t          r,
        input logic [io_map_pkg::PORT_COUNT-1:0]   empty_flags,
        input logic [io_map_pkg::PORT_COUNT-1:0]   full_flags
    );
        io_access_pkg::access_result_t       e;
        logic [io_map_pkg::PORT_COUNT-1:0]   rd_en;
        logic [io_map_pkg::PORT_COUNT-1:0]   wr_en;
        logic                                rd_blocked;
        logic                                wr_blocked;
        model_side(r.op == io_access_pkg::OP_READ || r.op == io_access_pkg::OP_READ_WRITE,
                   r.rd_addr, RD_BASE, empty_flags, rd_en, rd_blocked);
        model_side(r.op == io_access_pkg::OP_WRITE || r.op == io_access_pkg::OP_READ_WRITE,
                   r.wr_addr, WR_BASE, full_flags, wr_en, wr_blocked);
        e.annulled = rd_blocked | wr_blocked;
        e.rden     = e.annulled ? '0 : rd_en;
        e.wren     = e.annulled ? '0 : wr_en;
        e.tag      = r.tag;
        return e;
    endfunction

    // --------------------
    // Monitor and checks

    always @(posedge clock) begin
        io_access_pkg::access_result_t expected;
        int latency;
        if (!rst) begin
            // A result that was offered and not taken must still be there and unchanged
            if (hold_pending) begin
                assert (result_valid) else begin
                    $display("Offered result with tag %h was withdrawn before it was taken",
                             held_result.tag);
                    check_errors++;
                end
                assert (result == held_result) else begin
                    $display("ERROR result: got %h, expected %h while held", result, held_result);
                    check_errors++;
                end
            end
            if (req_valid && req_ready) begin
                expected_q.push_back(expected_result(req, rd_empty, wr_full));
                accept_cycle_q.push_back(cycle_count);
                latency_q.push_back(!random_ready);
            end
            if (result_valid && result_ready) begin
                if (expected_q.size() == 0) begin
                    $display("Result with tag %h arrived with no request outstanding", result.tag);
                    check_errors++;
                end else begin
                    expected = expected_q.pop_front();
                    latency  = cycle_count - accept_cycle_q.pop_front();
                    assert (result.rden == expected.rden) else begin
                        $display("ERROR result.rden: got %h, expected %h", result.rden,
                                 expected.rden);
                        check_errors++;
                    end
                    assert (result.wren == expected.wren) else begin
                        $display("ERROR result.wren: got %h, expected %h", result.wren,
                                 expected.wren);
                        check_errors++;
                    end
                    assert (result.annulled == expected.annulled) else begin
                        $display("ERROR result.annulled: got %h, expected %h", result.annulled,
                                 expected.annulled);
                        check_errors++;
                    end
                    assert (result.tag == expected.tag) else begin
                        $display("ERROR result.tag: got %h, expected %h", result.tag,
                                 expected.tag);
                        check_errors++;
                    end
                    if (latency_q.pop_front()) begin
                        assert (latency == 3) else begin
                            $display("ERROR result latency: got %h, expected %h", latency, 3);
                            check_errors++;
                        end
                    end
                end
            end
            hold_pending = result_valid && !result_ready;
            held_result  = result;
        end
        cycle_count++;
    end

    // --------------------
    // Stimulus

    // Called once after every falling edge, so all random draws come from one process
    task automatic update_result_ready;
        logic [31:0] word;
        if (random_ready) begin
            word         = $random(seed);
            result_ready = word[0] | word[1];
        end else begin
            result_ready = 1'b1;
        end
    endtask

    task automatic send_request(
        input io_access_pkg::op_e                  op,
        input logic [io_map_pkg::ADDR_WIDTH-1:0]   rd_addr,
        input logic [io_map_pkg::ADDR_WIDTH-1:0]   wr_addr,
        input logic [io_map_pkg::PORT_COUNT-1:0]   empty_flags,
        input logic [io_map_pkg::PORT_COUNT-1:0]   full_flags
    );
        @(negedge clock);
        update_result_ready();
        req.op      = op;
        req.rd_addr = rd_addr;
        req.wr_addr = wr_addr;
        req.tag     = next_tag;
        req_valid   = 1'b1;
        rd_empty    = empty_flags;
        wr_full     = full_flags;
        next_tag    = next_tag + 1'b1;
        #1;
        while (!req_ready) begin
            @(negedge clock);
            update_result_ready();
            #1;
        end
        @(posedge clock);
    endtask

    // Flags keep changing while idle, which must not reach accesses in flight
    task automatic idle_cycles(input int count);
        logic [31:0] word;
        repeat (count) begin
            @(negedge clock);
            update_result_ready();
            word      = $random(seed);
            req_valid = 1'b0;
            rd_empty  = word[3:0];
            wr_full   = word[7:4];
        end
    endtask

    task automatic wait_for_drain;
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < 200) begin
            @(negedge clock);
            update_result_ready();
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("%0d results never left the pipeline", expected_q.size());
            sequence_errors++;
        end
    endtask

    // Addresses from two below the base to two above the window end
    function automatic logic [io_map_pkg::ADDR_WIDTH-1:0] random_address(
        input logic [io_map_pkg::ADDR_WIDTH-1:0] base,
        input logic [13:0]                       r
    );
        if (r[3]) begin
            return r[13:4];
        end
        return base + 10'(r[2:0]) - 10'd2;
    endfunction

    initial begin
        int          i;
        logic [31:0] word_a;
        logic [31:0] word_b;
        rst          = 1'b1;
        req          = '0;
        req_valid    = 1'b0;
        rd_empty     = '0;
        wr_full      = '0;
        result_ready = 1'b0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        #1;
        assert (result_valid == 1'b0) else begin
            $display("ERROR result_valid: got %h, expected %h after reset", result_valid, 1'b0);
            sequence_errors++;
        end
        assert (req_ready == 1'b1) else begin
            $display("ERROR req_ready: got %h, expected %h after reset", req_ready, 1'b1);
            sequence_errors++;
        end

        // Accesses that touch no I/O port while all flags are set
        send_request(io_access_pkg::OP_NONE, 10'h200, 10'h300, 4'hf, 4'hf);
        send_request(io_access_pkg::OP_READ, 10'h1ff, 10'h300, 4'hf, 4'hf);
        send_request(io_access_pkg::OP_READ, 10'h204, 10'h300, 4'hf, 4'hf);
        send_request(io_access_pkg::OP_WRITE, 10'h200, 10'h2ff, 4'hf, 4'hf);
        send_request(io_access_pkg::OP_WRITE, 10'h200, 10'h304, 4'hf, 4'hf);
        send_request(io_access_pkg::OP_READ_WRITE, 10'h300, 10'h200, 4'hf, 4'hf);

        // Ready ports while the unused side is fully blocked
        for (i = 0; i < 4; i++) begin
            send_request(io_access_pkg::OP_READ, RD_BASE + 10'(i), 10'h000, 4'h0, 4'hf);
        end
        for (i = 0; i < 4; i++) begin
            send_request(io_access_pkg::OP_WRITE, 10'h000, WR_BASE + 10'(i), 4'hf, 4'h0);
        end
        send_request(io_access_pkg::OP_READ_WRITE, 10'h202, 10'h301, 4'b1011, 4'b1101);

        // Not-ready ports annul the whole access
        send_request(io_access_pkg::OP_READ, 10'h201, 10'h000, 4'b0010, 4'h0);
        send_request(io_access_pkg::OP_WRITE, 10'h000, 10'h303, 4'h0, 4'b1000);
        send_request(io_access_pkg::OP_READ_WRITE, 10'h200, 10'h302, 4'h0, 4'b0100);
        send_request(io_access_pkg::OP_READ_WRITE, 10'h203, 10'h300, 4'b1000, 4'h0);
        idle_cycles(1);
        wait_for_drain();

        // Random traffic with back pressure on the result side
        random_ready = 1'b1;
        for (i = 0; i < RANDOM_REQUESTS; i++) begin
            word_a = $random(seed);
            word_b = $random(seed);
            send_request(io_access_pkg::op_e'(word_a[1:0]),
                         random_address(RD_BASE, word_a[15:2]),
                         random_address(WR_BASE, word_b[13:0]),
                         word_a[19:16] & word_a[23:20],
                         word_b[19:16] & word_b[23:20]);
            if (word_b[24]) begin
                idle_cycles(1);
            end
        end
        idle_cycles(1);
        wait_for_drain();

        $display("Summary: %0d result errors, %0d sequence errors", check_errors,
                 sequence_errors);
        if (check_errors == 0 && sequence_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // --------------------
    // Watchdog

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired before the test sequence finished");
        $display("Something failed");
        $finish;
    end

endmodule

/* build.f */
io_map_pkg.sv
io_access_pkg.sv
io_port_check.sv
io_port_select.sv
io_access_predication.sv
io_issue_control.sv
io_predication_top.sv
tb_io_predication.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_io_predication
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message shows up on a line of its own
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
